/* bench/ddr3_rd_model.sv */
`timescale 1ns/1ns

module ddr3_rd_model (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [31:0]                   rnd,           // new random bits every cycle
    input  ddr_rd_pkg::addr_t             ddr_addr,
    input  logic [ddr_rd_pkg::BLEN_W-1:0] ddr_len,
    input  ddr_rd_pkg::id_t               ddr_id,
    input  logic                          ddr_addr_valid,
    output logic                          ddr_addr_ready,
    output ddr_rd_pkg::line_t             ddr_data,
    output ddr_rd_pkg::id_t               ddr_back_id,
    output logic                          ddr_data_last,
    output logic                          ddr_data_valid
);

    ddr_rd_pkg::addr_t line_addr;      // next line to return
    ddr_rd_pkg::id_t   burst_id;
    int beats_left;                    // lines after the current one
    int delay;
    int k;
    bit busy;

    // all outputs change on the falling edge
    initial begin
        ddr_addr_ready = 1'b0;
        ddr_data       = '0;
        ddr_back_id    = '0;
        ddr_data_last  = 1'b0;
        ddr_data_valid = 1'b0;
        busy           = 1'b0;
        forever begin
            @(negedge clk);
            ddr_addr_ready = 1'b0;
            ddr_data_valid = 1'b0;
            ddr_data_last  = 1'b0;
            if (!rstn) begin
                busy = 1'b0;
            end else if (busy && delay != 0) begin
                delay--;
            end else if (busy) begin
                for (k = 0; k < ddr_rd_pkg::WORDS_PER_LINE; k++)
                    ddr_data[k*ddr_rd_pkg::WORD_W +: ddr_rd_pkg::WORD_W] =
                        {4'ha, ddr_rd_pkg::addr_t'(line_addr + k)};
                ddr_back_id    = burst_id;
                ddr_data_valid = 1'b1;
                ddr_data_last  = (beats_left == 0);
                busy           = (beats_left != 0);
                beats_left--;
                line_addr = line_addr + ddr_rd_pkg::addr_t'(ddr_rd_pkg::WORDS_PER_LINE);
            end else if (ddr_addr_valid && rnd[27:26] != 2'b00) begin
                ddr_addr_ready = 1'b1;             // handshake on the coming rising edge
                line_addr      = ddr_addr;
                burst_id       = ddr_id;
                beats_left     = int'(ddr_len);
                delay          = int'(rnd[31:29]);  // first line 1 to 8 cycles later
                busy           = 1'b1;
            end
        end
    end

endmodule

/* bench/tb_ddr3_read.sv */
`timescale 1ns/1ns

module tb_ddr3_read;

    localparam int N_TRANS          = 6;       // requests over all tests
    localparam int CYCLES_PER_TRANS = 400;

    logic clk;
    logic rstn;
    ddr_rd_pkg::id_t rd_addr_id;
    ddr_rd_pkg::addr_t rd_addr;
    logic [ddr_rd_pkg::LEN_W-1:0] rd_addr_len;
    logic rd_addr_valid, rd_addr_ready;
    ddr_rd_pkg::id_t rd_back_id;
    ddr_rd_pkg::word_t rd_data;
    logic rd_data_last, rd_data_valid, rd_data_ready;
    ddr_rd_pkg::addr_t ddr_addr;
    logic [ddr_rd_pkg::BLEN_W-1:0] ddr_len;
    ddr_rd_pkg::id_t ddr_id, ddr_back_id;
    logic ddr_addr_valid, ddr_addr_ready;
    ddr_rd_pkg::line_t ddr_data;
    logic ddr_data_last, ddr_data_valid;

    logic [31:0] lcg_state;
    bit rand_ready;                    // throttle rd_data_ready
    ddr_rd_pkg::addr_t req_start;      // first line of the latest request
    ddr_rd_pkg::id_t req_id;           // id of the latest request
    int req_lines;                     // lines spanned by the latest request
    int req_count;
    ddr_rd_pkg::addr_t next_burst;
    int lines_left;                    // lines not yet asked for
    int exp_len;
    int seen_req;
    int burst_lens[$];                 // lines per burst, in issue order
    int n_checks;
    int n_errors;
    int mon_errors;

    ddr3_read u_ddr3_read (.*);

    ddr3_rd_model u_ddr (.rnd(lcg_state), .*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // every stored word carries its own address
    function automatic ddr_rd_pkg::word_t word_at(input ddr_rd_pkg::addr_t a);
        return {4'ha, a};
    endfunction

    task automatic check_word(input ddr_rd_pkg::word_t got, input ddr_rd_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: rd_data %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_id(input ddr_rd_pkg::id_t got, input ddr_rd_pkg::id_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: rd_back_id %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_last(input bit got, input bit exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: rd_data_last %b, expected %b", $time, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        lcg_state = 32'hb2db;
        forever begin
            @(posedge clk);
            lcg_state <= lcg_step(lcg_state);
        end
    end

    // ddr address channel monitor
    initial begin
        mon_errors = 0;
        seen_req   = 0;
        next_burst = '0;
        lines_left = 0;
        forever begin
            @(posedge clk);
            if (rstn && ddr_addr_valid && ddr_addr_ready) begin
                if (seen_req != req_count) begin
                    next_burst = req_start;          // first burst of a new request
                    lines_left = req_lines;
                    seen_req   = req_count;
                end
                exp_len = (lines_left > ddr_rd_pkg::MAX_BURST_LINES)
                        ? ddr_rd_pkg::MAX_BURST_LINES : lines_left;
                if (ddr_addr[ddr_rd_pkg::OFS_W-1:0] != '0 || ddr_addr !== next_burst
                    || int'(ddr_len) + 1 != exp_len || ddr_id !== req_id) begin
                    mon_errors++;
                    $display("Error at %0t: burst at %h of %0d lines id %h, expected %h %0d %h",
                             $time, ddr_addr, int'(ddr_len) + 1, ddr_id,
                             next_burst, exp_len, req_id);
                end
                burst_lens.push_back(int'(ddr_len) + 1);
                lines_left = lines_left - (int'(ddr_len) + 1);
                next_burst = ddr_addr
                           + ddr_rd_pkg::addr_t'((int'(ddr_len) + 1) * ddr_rd_pkg::WORDS_PER_LINE);
            end
        end
    end

    initial begin
        repeat (N_TRANS * CYCLES_PER_TRANS + 20) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic send_request(input ddr_rd_pkg::id_t id, input ddr_rd_pkg::addr_t addr,
                                input int nwords);
        int cycles;
        cycles        = 0;
        rd_addr_id    = id;
        rd_addr       = addr;
        rd_addr_len   = ddr_rd_pkg::LEN_W'(nwords - 1);
        rd_addr_valid = 1'b1;
        while (!rd_addr_ready && cycles < CYCLES_PER_TRANS) begin
            @(negedge clk);
            cycles++;
        end
        if (!rd_addr_ready) begin
            n_errors++;
            $display("request with id %0d was never accepted", id);
        end
        req_start = {addr[ddr_rd_pkg::ADDR_W-1:ddr_rd_pkg::OFS_W], {ddr_rd_pkg::OFS_W{1'b0}}};
        req_id    = id;
        // head offset plus words, rounded up to whole lines
        req_lines = (int'(addr[ddr_rd_pkg::OFS_W-1:0]) + nwords
                     + ddr_rd_pkg::WORDS_PER_LINE - 1) / ddr_rd_pkg::WORDS_PER_LINE;
        req_count++;
        @(negedge clk);
        rd_addr_valid = 1'b0;
    endtask

    // valid does not depend on ready, so the handshake is known at the falling edge
    task automatic receive_words(input ddr_rd_pkg::id_t id, input ddr_rd_pkg::addr_t start,
                                 input int nwords);
        int got;
        got = 0;
        while (got < nwords) begin
            @(negedge clk);
            rd_data_ready = rand_ready ? lcg_state[30] : 1'b1;
            if (rd_addr_ready) begin
                n_errors++;
                $display("rd_addr_ready went high before the last word of id %0d", id);
            end
            if (rd_data_valid && rd_data_ready) begin
                check_word(rd_data, word_at(ddr_rd_pkg::addr_t'(start + got)));
                check_id(rd_back_id, id);
                check_last(rd_data_last, got == nwords - 1);
                got++;
            end
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (rd_data_valid) begin
                n_errors++;
                $display("a word was presented after the last word");
            end
        end while (!rd_addr_ready && cycles < 20);
        if (!rd_addr_ready) begin
            n_errors++;
            $display("the bridge did not return to idle after the last word");
        end
    endtask

    task automatic run_read(input ddr_rd_pkg::id_t id, input ddr_rd_pkg::addr_t addr,
                            input int nwords);
        send_request(id, addr, nwords);
        receive_words(id, addr, nwords);
        wait_idle();
    endtask

    task automatic test_single_word();
        run_read(4'h1, 28'h0000100, 1);
    endtask

    task automatic test_unaligned();
        run_read(4'h2, 28'h0123455, 20);     // offset 5, crosses three line boundaries
    endtask

    task automatic test_long_read();
        int first;
        first = burst_lens.size();
        run_read(4'h3, 28'h0300043, 256);    // 33 lines
        if (burst_lens.size() != first + 3) begin
            n_errors++;
            $display("long read used %0d bursts instead of 3", burst_lens.size() - first);
        end else if (burst_lens[first] != 16 || burst_lens[first+1] != 16
                     || burst_lens[first+2] != 1) begin
            n_errors++;
            $display("long read bursts were %0d, %0d and %0d lines instead of 16, 16 and 1",
                     burst_lens[first], burst_lens[first+1], burst_lens[first+2]);
        end
    endtask

    task automatic test_backpressure();
        rand_ready = 1'b1;
        run_read(4'h4, 28'h0400083, 200);
        rand_ready = 1'b0;
    endtask

    task automatic test_back_to_back();
        send_request(4'h5, 28'h050000a, 13);
        rd_addr_id    = 4'ha;               // second request already waiting
        rd_addr       = 28'h0600016;
        rd_addr_len   = 8'd8;
        rd_addr_valid = 1'b1;
        receive_words(4'h5, 28'h050000a, 13);
        send_request(4'ha, 28'h0600016, 9);
        receive_words(4'ha, 28'h0600016, 9);
        wait_idle();
    endtask

    initial begin
        rstn          = 1'b0;
        rd_addr_id    = '0;
        rd_addr       = '0;
        rd_addr_len   = '0;
        rd_addr_valid = 1'b0;
        rd_data_ready = 1'b0;
        rand_ready    = 1'b0;
        req_start     = '0;
        req_id        = '0;
        req_lines     = 0;
        req_count     = 0;
        n_checks      = 0;
        n_errors      = 0;
        repeat (10) @(negedge clk);
        rstn          = 1'b1;
        rd_data_ready = 1'b1;
        @(negedge clk);
        if (!rd_addr_ready || rd_data_valid || rd_data_last || ddr_addr_valid) begin
            n_errors++;
            $display("outputs after reset are wrong, only rd_addr_ready should be high");
        end
        test_single_word();
        test_unaligned();
        test_long_read();
        test_backpressure();
        test_back_to_back();
        $display("checks %0d, data errors %0d, burst errors %0d", n_checks, n_errors, mon_errors);
        if (n_errors == 0 && mon_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* compile.f */
verilog/ddr_rd_pkg.sv
verilog/fifo_ddr3_read.sv
verilog/ddr3_read.sv
bench/ddr3_rd_model.sv
bench/tb_ddr3_read.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr3_read \
    -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verilog/ddr3_read.sv */
`timescale 1ns/1ns

module ddr3_read (
    input  logic                          clk,
    input  logic                          rstn,

    // slave request channel
    input  ddr_rd_pkg::id_t               rd_addr_id,
    input  ddr_rd_pkg::addr_t             rd_addr,
    input  logic [ddr_rd_pkg::LEN_W-1:0]  rd_addr_len,     // words minus one
    input  logic                          rd_addr_valid,
    output logic                          rd_addr_ready,

    // slave data channel
    output ddr_rd_pkg::id_t               rd_back_id,
    output ddr_rd_pkg::word_t             rd_data,
    output logic                          rd_data_last,
    output logic                          rd_data_valid,
    input  logic                          rd_data_ready,

    // ddr address channel
    output ddr_rd_pkg::addr_t             ddr_addr,
    output logic [ddr_rd_pkg::BLEN_W-1:0] ddr_len,         // lines minus one
    output ddr_rd_pkg::id_t               ddr_id,
    output logic                          ddr_addr_valid,
    input  logic                          ddr_addr_ready,

    // ddr data channel without back-pressure
    input  ddr_rd_pkg::line_t             ddr_data,
    input  ddr_rd_pkg::id_t               ddr_back_id,
    input  logic                          ddr_data_last,
    input  logic                          ddr_data_valid
);

    ddr_rd_pkg::rd_state_t state;
    ddr_rd_pkg::rd_state_t state_nxt;

    ddr_rd_pkg::id_t   id_q;
    ddr_rd_pkg::addr_t addr_q;                              // start of the next burst
    ddr_rd_pkg::addr_t addr_end;
    logic [ddr_rd_pkg::LINE_ADDR_W-1:0] lines_q;            // lines still to request, minus one
    logic [ddr_rd_pkg::LINE_ADDR_W-1:0] burst_lines;
    logic [ddr_rd_pkg::OFS_W-1:0] skip_q;                   // head words still to drop
    logic [ddr_rd_pkg::LEN_W-1:0] words_q;                  // zero on the last word
    logic bursts_done;
    logic last_burst;

    // fifo output register holds a popped word that is not used yet
    logic out_vld;

    logic accept;
    logic addr_hs;
    logic data_hs;
    logic last_hs;
    logic active;
    logic dropping;
    logic take;

    logic fifo_rst;
    logic fifo_rd_en;
    logic fifo_empty;
    logic fifo_almost_empty;
    ddr_rd_pkg::word_t fifo_rd_data;

    assign accept  = rd_addr_valid && rd_addr_ready;
    assign addr_hs = ddr_addr_valid && ddr_addr_ready;
    assign data_hs = rd_data_valid && rd_data_ready;
    assign last_hs = data_hs && rd_data_last;

    assign addr_end = rd_addr + ddr_rd_pkg::addr_t'(rd_addr_len);

    // 16 lines or more left means a full burst
    assign last_burst  = ~|lines_q[ddr_rd_pkg::LINE_ADDR_W-1:ddr_rd_pkg::BLEN_W];
    assign ddr_len     = last_burst ? lines_q[ddr_rd_pkg::BLEN_W-1:0] : '1;
    assign burst_lines = {{(ddr_rd_pkg::LINE_ADDR_W-ddr_rd_pkg::BLEN_W){1'b0}}, ddr_len} + 1'b1;

    always_comb begin
        state_nxt = state;
        case (state)
            ddr_rd_pkg::IDLE: begin
                if (accept)
                    state_nxt = ddr_rd_pkg::WAIT;
            end
            ddr_rd_pkg::WAIT: begin
                if (last_hs)
                    state_nxt = ddr_rd_pkg::FLUSH;
                else if (fifo_almost_empty && !bursts_done)
                    state_nxt = ddr_rd_pkg::TRANS_ADDR;
            end
            ddr_rd_pkg::TRANS_ADDR: begin
                if (addr_hs)
                    state_nxt = ddr_rd_pkg::TRANS_DATA;
            end
            ddr_rd_pkg::TRANS_DATA: begin
                if (ddr_data_valid && ddr_data_last)
                    state_nxt = ddr_rd_pkg::WAIT;
            end
            ddr_rd_pkg::FLUSH: state_nxt = ddr_rd_pkg::IDLE;
            default:           state_nxt = ddr_rd_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= ddr_rd_pkg::IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_q   <= rd_addr_id;
            addr_q <= {rd_addr[ddr_rd_pkg::ADDR_W-1:ddr_rd_pkg::OFS_W], {ddr_rd_pkg::OFS_W{1'b0}}};
        end else if (addr_hs && !last_burst) begin
            addr_q <= addr_q + {burst_lines, {ddr_rd_pkg::OFS_W{1'b0}}};
        end
    end

    // burst bookkeeping
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lines_q     <= '0;
            bursts_done <= 1'b0;
        end else if (accept) begin
            lines_q     <= addr_end[ddr_rd_pkg::ADDR_W-1:ddr_rd_pkg::OFS_W]
                         - rd_addr[ddr_rd_pkg::ADDR_W-1:ddr_rd_pkg::OFS_W];
            bursts_done <= 1'b0;
        end else if (addr_hs) begin
            if (last_burst)
                bursts_done <= 1'b1;
            else
                lines_q <= lines_q - burst_lines;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            skip_q  <= '0;
            words_q <= '0;
        end else if (accept) begin
            skip_q  <= rd_addr[ddr_rd_pkg::OFS_W-1:0];   // offset of the first word
            words_q <= rd_addr_len;
        end else begin
            if (dropping)
                skip_q <= skip_q - 1'b1;
            if (data_hs && (words_q != '0))
                words_q <= words_q - 1'b1;
        end
    end

    assign active = (state == ddr_rd_pkg::WAIT) || (state == ddr_rd_pkg::TRANS_ADDR)
                 || (state == ddr_rd_pkg::TRANS_DATA);

    assign dropping = out_vld && (skip_q != '0);
    assign take     = dropping || data_hs;       // output word leaves the register

    // refill the output register when it is free or being emptied
    assign fifo_rd_en = active && !fifo_empty && (!out_vld || take);

    always_ff @(posedge clk) begin
        if (!rstn || !active)
            out_vld <= 1'b0;
        else if (fifo_rd_en)
            out_vld <= 1'b1;
        else if (take)
            out_vld <= 1'b0;
    end

    assign rd_data_valid = active && out_vld && (skip_q == '0);
    assign rd_data_last  = rd_data_valid && (words_q == '0);
    assign rd_data       = fifo_rd_data;
    assign rd_back_id    = id_q;    // in-order only

    assign rd_addr_ready  = rstn && (state == ddr_rd_pkg::IDLE);
    assign ddr_addr       = addr_q;
    assign ddr_id         = id_q;
    assign ddr_addr_valid = (state == ddr_rd_pkg::TRANS_ADDR);

    assign fifo_rst = !rstn || (state == ddr_rd_pkg::FLUSH);

    fifo_ddr3_read u_fifo (
        .clk          (clk),
        .rst          (fifo_rst),
        .wr_en        (ddr_data_valid),
        .wr_data      (ddr_data),
        .rd_en        (fifo_rd_en),
        .rd_data      (fifo_rd_data),
        .empty        (fifo_empty),
        .almost_empty (fifo_almost_empty)
    );

    a_ddr_addr_hold: assert property (@(posedge clk) disable iff (!rstn)
        ddr_addr_valid && !ddr_addr_ready |=>
            ddr_addr_valid && $stable(ddr_addr) && $stable(ddr_len) && $stable(ddr_id));

    a_rd_data_hold: assert property (@(posedge clk) disable iff (!rstn)
        rd_data_valid && !rd_data_ready |=>
            rd_data_valid && $stable(rd_data) && $stable(rd_data_last));

    // returned lines belong to the burst in flight
    a_ddr_beat_in_burst: assert property (@(posedge clk) disable iff (!rstn)
        ddr_data_valid |-> (state == ddr_rd_pkg::TRANS_DATA) && (ddr_back_id == id_q));

endmodule

/* verilog/ddr_rd_pkg.sv */
package ddr_rd_pkg;

    localparam int ADDR_W          = 28;                          // word address
    localparam int WORD_W          = 32;
    localparam int LINE_W          = 256;
    localparam int WORDS_PER_LINE  = LINE_W / WORD_W;
    localparam int OFS_W           = $clog2(WORDS_PER_LINE);      // word offset in a line
    localparam int LINE_ADDR_W     = ADDR_W - OFS_W;
    localparam int ID_W            = 4;
    localparam int LEN_W           = 8;                           // words minus one
    localparam int BLEN_W          = 4;                           // lines minus one
    localparam int MAX_BURST_LINES = 16;

    localparam int FIFO_LINES      = 32;
    localparam int LPTR_W          = $clog2(FIFO_LINES);
    localparam int WCNT_W          = LPTR_W + OFS_W + 1;          // occupancy in words
    localparam int REFILL_LEVEL    = FIFO_LINES - MAX_BURST_LINES;

    // more words than this and a whole line no longer fits
    localparam logic [WCNT_W-1:0] FULL_WORDS   = WCNT_W'((FIFO_LINES - 1) * WORDS_PER_LINE);
    localparam logic [WCNT_W-1:0] REFILL_WORDS = WCNT_W'(REFILL_LEVEL * WORDS_PER_LINE);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0]   id_t;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        WAIT       = 3'd1,    // waiting for fifo room or for the last word
        TRANS_ADDR = 3'd2,
        TRANS_DATA = 3'd3,
        FLUSH      = 3'd4     // drops the tail of the final line
    } rd_state_t;

endpackage

/* verilog/fifo_ddr3_read.sv */
`timescale 1ns/1ns

module fifo_ddr3_read (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  ddr_rd_pkg::line_t wr_data,
    input  logic              rd_en,
    output ddr_rd_pkg::word_t rd_data,
    output logic              empty,
    output logic              almost_empty
);

    ddr_rd_pkg::line_t mem [ddr_rd_pkg::FIFO_LINES];

    // line pointer with the wrap bit on top
    logic [ddr_rd_pkg::LPTR_W:0] wr_ptr;
    // word pointer laid out as {wrap, line, word}
    logic [ddr_rd_pkg::LPTR_W+ddr_rd_pkg::OFS_W:0] rd_ptr;
    logic [ddr_rd_pkg::LPTR_W-1:0] rd_line;
    logic [ddr_rd_pkg::OFS_W-1:0] rd_word;
    logic [ddr_rd_pkg::WCNT_W-1:0] word_cnt;
    logic full;

    assign rd_line = rd_ptr[ddr_rd_pkg::LPTR_W+ddr_rd_pkg::OFS_W-1:ddr_rd_pkg::OFS_W];
    assign rd_word = rd_ptr[ddr_rd_pkg::OFS_W-1:0];

    // write pointer scaled up to words, difference wraps cleanly
    assign word_cnt = {wr_ptr, {ddr_rd_pkg::OFS_W{1'b0}}} - rd_ptr;

    assign empty        = (word_cnt == '0);
    assign full         = (word_cnt > ddr_rd_pkg::FULL_WORDS);
    assign almost_empty = (word_cnt <= ddr_rd_pkg::REFILL_WORDS);  // a full burst still fits

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ddr_rd_pkg::LPTR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;     // carries into the line index after word 7
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_line][rd_word*ddr_rd_pkg::WORD_W +: ddr_rd_pkg::WORD_W];
        end
    end

    // the bridge only requests a burst once the fifo has drained below refill level
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> !empty);

endmodule
